// File: run.sh
#!/usr/bin/env bash
# Builds the item memory generator testbench with Verilator and runs it.
# Exits non-zero when the build fails, the simulation fails, or the
# testbench reports a failure in its log.

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_item_memory_gen
OBJ_DIR=obj_dir
LOG=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert \
    --top-module "$TOP" \
    --Mdir "$OBJ_DIR" \
    -f verilog.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q -- ">>> FAIL" "$LOG"; then
    echo "testbench reported a failure, see $LOG"
    exit 1
fi

exit 0

// File: tb/axil_slave_fsm_chk.sv
`default_nettype none
`timescale 1ns/1ns

module axil_slave_fsm_chk (
    input logic                AXIS_ACLK,
    input logic                S_AXI_ARESETN,
    input axil_pkg::axil_req_t axil_req,
    input axil_pkg::axil_rsp_t axil_rsp,
    input axil_pkg::reg_wr_t   reg_wr
);

    // write and read responses never overlap
    a_one_response: assert property (
        @(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        !(axil_rsp.bvalid && axil_rsp.rvalid)
    ) else $error("bvalid and rvalid are high in the same cycle");

    // ------------------------------------------------------------------------
    // responses held until accepted
    // ------------------------------------------------------------------------
    a_bvalid_hold: assert property (
        @(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        (axil_rsp.bvalid && !axil_req.bready) |=> axil_rsp.bvalid
    ) else $error("bvalid dropped before bready");

    a_rvalid_hold: assert property (
        @(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        (axil_rsp.rvalid && !axil_req.rready) |=> (axil_rsp.rvalid && $stable(axil_rsp.rdata))
    ) else $error("rvalid or rdata changed before rready");

    // register strobe is a single-cycle pulse
    a_strobe_pulse: assert property (
        @(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        reg_wr.valid |=> !reg_wr.valid
    ) else $error("register write strobe lasted more than one cycle");

endmodule

bind axil_slave_fsm axil_slave_fsm_chk u_axil_slave_fsm_chk (
    .AXIS_ACLK     (AXIS_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .axil_req      (axil_req),
    .axil_rsp      (axil_rsp),
    .reg_wr        (reg_wr)
);

`default_nettype wire

// File: tb/tb_item_memory_gen.sv
`default_nettype none
`timescale 1ns/1ns

module tb_item_memory_gen;
    import axil_pkg::*;
    import itemgen_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int WAIT_LIMIT  = 64;
    localparam int SEL_AWREADY = 0;
    localparam int SEL_WREADY  = 1;
    localparam int SEL_ARREADY = 2;
    localparam int SEL_BVALID  = 3;
    localparam int SEL_RVALID  = 4;

    logic      AXIS_ACLK;
    logic      S_AXI_ARESETN;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    item_wr_t  item_wr;

    integer   seed;
    int       error_count;
    int       timeout_count;
    int       writes_issued;
    int       b_seen;
    int       cycle_count;
    int       last_pulse;
    item_wr_t expected_q[$];

    item_memory_gen_top DUT (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .axil_req      (axil_req),
        .axil_rsp      (axil_rsp),
        .item_wr       (item_wr)
    );

    initial begin
        AXIS_ACLK = 1'b0;
        forever #(CLK_PERIOD / 2) AXIS_ACLK = ~AXIS_ACLK;
    end

    task automatic check_value(input string name, input logic [HV_W-1:0] got,
                               input logic [HV_W-1:0] want);
        if (got !== want) begin
            error_count = error_count + 1;
            $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
        end
    endtask

    task automatic report_timeout(input string what, input int limit);
        timeout_count = timeout_count + 1;
        $display("Timeout: %s did not happen within %0d cycles at %0t", what, limit, $time);
    endtask

    // xorshift32 step with shifts left then right then left
    function automatic logic [31:0] model_xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << XS_A);
        y = y ^ (y >> XS_B);
        y = y ^ (y << XS_C);
        return y;
    endfunction

    // queue up items 0 to last as one sequence from the seed
    task automatic expect_items(input int last);
        logic [31:0] x;
        item_wr_t    item;
        x = PRNG_SEED;
        for (int n = 0; n <= last; n++) begin
            item.valid = 1'b1;
            item.addr  = n[ITEM_A_W-1:0];
            for (int k = 0; k < HV_WORDS; k++) begin
                item.vector[32*k +: 32] = x;
                x = model_xorshift(x);
            end
            expected_q.push_back(item);
        end
    endtask

    task automatic next_drive();
        @(posedge AXIS_ACLK);
        #1;
    endtask

    function automatic logic flag_value(input int sel);
        case (sel)
            SEL_AWREADY: return axil_rsp.awready;
            SEL_WREADY:  return axil_rsp.wready;
            SEL_ARREADY: return axil_rsp.arready;
            SEL_BVALID:  return axil_rsp.bvalid;
            default:     return axil_rsp.rvalid;
        endcase
    endfunction

    // polls at falling edges and counts the extra cycles in waited
    task automatic await_flag(input int sel, input string what, output int waited);
        waited = 0;
        @(negedge AXIS_ACLK);
        while (!flag_value(sel) && waited < WAIT_LIMIT) begin
            @(negedge AXIS_ACLK);
            waited = waited + 1;
        end
        if (!flag_value(sel)) begin
            report_timeout(what, WAIT_LIMIT);
        end
    endtask

    // ------------------------------------------------------------------------
    // bus tasks
    // ------------------------------------------------------------------------
    // mode 0 sends AW and W together, 1 sends AW first, 2 sends W first
    task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input int mode);
        logic [31:0] r;
        int          aw_delay;
        int          w_delay;
        int          hold;
        int          waited;
        r = $random(seed);
        aw_delay = (mode == 2) ? 1 + int'(r[1:0]) : 0;
        w_delay  = (mode == 1) ? 1 + int'(r[1:0]) : 0;
        hold = int'(r[3:2]);
        writes_issued = writes_issued + 1;
        next_drive();
        fork
            begin
                int aw_wait;
                repeat (aw_delay) next_drive();
                axil_req.awaddr  = addr;
                axil_req.awvalid = 1'b1;
                await_flag(SEL_AWREADY, "write address handshake", aw_wait);
                next_drive();
                axil_req.awvalid = 1'b0;
            end
            begin
                int w_wait;
                repeat (w_delay) next_drive();
                axil_req.wdata  = data;
                axil_req.wvalid = 1'b1;
                await_flag(SEL_WREADY, "write data handshake", w_wait);
                next_drive();
                axil_req.wvalid = 1'b0;
            end
        join
        repeat (hold) next_drive();
        axil_req.bready = 1'b1;
        await_flag(SEL_BVALID, "write response", waited);
        check_value("bvalid wait", HV_W'(waited), HV_W'(0));
        check_value("bresp", HV_W'(axil_rsp.bresp), HV_W'(RESP_OKAY));
        next_drive();
        axil_req.bready = 1'b0;
        @(negedge AXIS_ACLK);
        check_value("bvalid after response", HV_W'(axil_rsp.bvalid), HV_W'(0));
    endtask

    task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        logic [31:0] r;
        int          hold;
        int          waited;
        r = $random(seed);
        hold = int'(r[1:0]);
        next_drive();
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        await_flag(SEL_ARREADY, "read address handshake", waited);
        next_drive();
        axil_req.arvalid = 1'b0;
        await_flag(SEL_RVALID, "read data valid", waited);
        check_value("rvalid latency", HV_W'(waited + 1), HV_W'(2));
        check_value("rresp", HV_W'(axil_rsp.rresp), HV_W'(RESP_OKAY));
        data = axil_rsp.rdata;
        repeat (hold) next_drive();
        next_drive();
        axil_req.rready = 1'b1;
        next_drive();
        axil_req.rready = 1'b0;
        @(negedge AXIS_ACLK);
        check_value("rvalid after response", HV_W'(axil_rsp.rvalid), HV_W'(0));
    endtask

    // checks the item port and counts new write responses at falling edges
    task automatic watch_outputs();
        item_wr_t want;
        logic     bvalid_q;
        bvalid_q = 1'b0;
        forever begin
            @(negedge AXIS_ACLK);
            cycle_count = cycle_count + 1;
            if (axil_rsp.bvalid && !bvalid_q) begin
                b_seen = b_seen + 1;
            end
            bvalid_q = axil_rsp.bvalid;
            if (item_wr.valid) begin
                if (expected_q.size() == 0) begin
                    error_count = error_count + 1;
                    $display("Unexpected item write to address 0x%0h at %0t",
                             item_wr.addr, $time);
                end else begin
                    want = expected_q.pop_front();
                    check_value("item_wr.addr", HV_W'(item_wr.addr), HV_W'(want.addr));
                    check_value("item_wr.vector", item_wr.vector, want.vector);
                    if (want.addr != '0) begin
                        check_value("item_wr spacing", HV_W'(cycle_count - last_pulse),
                                    HV_W'(HV_WORDS));
                    end
                end
                last_pulse = cycle_count;
            end
        end
    endtask

    initial begin
        logic [DATA_W-1:0] rd;
        logic [31:0]       r;
        logic [ADDR_W-1:0] unmapped;
        int                first_last;
        int                item_n;
        int                gen_limit;
        int                waited;
        seed          = 32'h5905;
        error_count   = 0;
        timeout_count = 0;
        writes_issued = 0;
        b_seen        = 0;
        cycle_count   = 0;
        last_pulse    = 0;
        axil_req      = '0;
        S_AXI_ARESETN = 1'b0;
        fork
            watch_outputs();
        join_none
        repeat (4) @(posedge AXIS_ACLK);
        #1;
        S_AXI_ARESETN = 1'b1;

        // quiet outputs right after reset
        @(negedge AXIS_ACLK);
        check_value("bvalid", HV_W'(axil_rsp.bvalid), HV_W'(0));
        check_value("rvalid", HV_W'(axil_rsp.rvalid), HV_W'(0));
        check_value("item_wr.valid", HV_W'(item_wr.valid), HV_W'(0));
        bus_read(REG_CTRL_OFS, rd);
        check_value("ctrl after reset", HV_W'(rd), HV_W'(0));

        // ------------------------------------------------------------------------
        // register readback over all three write orderings
        // ------------------------------------------------------------------------
        for (int i = 0; i < 12; i++) begin
            r = $random(seed);
            bus_write(REG_ITEM_LAST_OFS, r, i % 3);
            bus_read(REG_ITEM_LAST_OFS, rd);
            check_value("item_last readback", HV_W'(rd), HV_W'(r[ITEM_A_W-1:0]));
            unmapped = 12'h008 + {1'b0, r[20:12], 2'b00};
            bus_write(unmapped, ~r, (i + 1) % 3);
            bus_read(unmapped, rd);
            check_value("unmapped readback", HV_W'(rd), HV_W'(0));
            bus_read(REG_ITEM_LAST_OFS, rd);
            check_value("item_last kept", HV_W'(rd), HV_W'(r[ITEM_A_W-1:0]));
        end

        // three generation runs where the last one repeats the first
        first_last = 0;
        for (int run = 0; run < 3; run++) begin
            r = $random(seed);
            item_n = int'(r % 32'd6);
            if (run == 0) begin
                first_last = item_n;
            end else if (run == 2) begin
                item_n = first_last;
            end
            bus_write(REG_ITEM_LAST_OFS, 32'(item_n), run % 3);
            expect_items(item_n);
            bus_write(REG_CTRL_OFS, 32'h1, (run + 1) % 3);
            gen_limit = HV_WORDS * (item_n + 2) + WAIT_LIMIT;
            waited = 0;
            while (expected_q.size() != 0 && waited < gen_limit) begin
                @(negedge AXIS_ACLK);
                waited = waited + 1;
            end
            if (expected_q.size() != 0) begin
                report_timeout("all item writes of a run", gen_limit);
                expected_q.delete();
            end
            bus_read(REG_CTRL_OFS, rd);
            check_value("gen after last item", HV_W'(rd), HV_W'(0));
            // quiet period after the last item
            repeat (4 * HV_WORDS) @(negedge AXIS_ACLK);
        end

        check_value("write responses", HV_W'(b_seen), HV_W'(writes_issued));
        $display("Summary: %0d check errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
verilog/axil_pkg.sv
verilog/itemgen_pkg.sv
verilog/axil_slave_fsm.sv
verilog/ctrl_regs.sv
verilog/item_counter.sv
verilog/hv_generator.sv
verilog/item_memory_gen_top.sv
tb/axil_slave_fsm_chk.sv
tb/tb_item_memory_gen.sv

// File: verilog/axil_pkg.sv
`default_nettype none

package axil_pkg;

    localparam int ADDR_W = 12;
    localparam int DATA_W = 32;

    // register map, word aligned
    localparam logic [ADDR_W-1:0] REG_CTRL_OFS      = 12'h000;
    localparam logic [ADDR_W-1:0] REG_ITEM_LAST_OFS = 12'h004;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef enum logic [2:0] {
        IDLE,
        ADDR_HELD,
        DATA_HELD,
        WRITE_RESP,
        READ_FETCH,
        READ_RESP
    } axil_state_e;

    // ------------------------------------------------------------------------
    // bus channels, master side and slave side
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [ADDR_W-1:0] awaddr;
        logic              awvalid;
        logic [DATA_W-1:0] wdata;
        logic              wvalid;
        logic              bready;
        logic [ADDR_W-1:0] araddr;
        logic              arvalid;
        logic              rready;
    } axil_req_t;

    typedef struct packed {
        logic              awready;
        logic              wready;
        logic              bvalid;
        logic [1:0]        bresp;
        logic              arready;
        logic              rvalid;
        logic [DATA_W-1:0] rdata;
        logic [1:0]        rresp;
    } axil_rsp_t;

    // one-cycle register write strobe
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] ofs;
        logic [DATA_W-1:0] data;
    } reg_wr_t;

endpackage

`default_nettype wire

// File: verilog/axil_slave_fsm.sv
`default_nettype none
`timescale 1ns/1ns

module axil_slave_fsm (
    input  logic                        AXIS_ACLK,
    input  logic                        S_AXI_ARESETN,
    input  axil_pkg::axil_req_t         axil_req,
    output axil_pkg::axil_rsp_t         axil_rsp,
    output axil_pkg::reg_wr_t           reg_wr,
    output logic [axil_pkg::ADDR_W-1:0] rd_ofs,
    input  logic [axil_pkg::DATA_W-1:0] rd_data
);
    import axil_pkg::*;

    axil_state_e       state;
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;
    logic [ADDR_W-1:0] rd_addr;
    logic [DATA_W-1:0] rdata_q;
    logic              wr_pulse;

    logic aw_hs;
    logic w_hs;
    logic ar_hs;

    // drop the byte lane bits
    function automatic logic [ADDR_W-1:0] word_ofs(input logic [ADDR_W-1:0] a);
        return {a[ADDR_W-1:2], 2'b00};
    endfunction

    // ------------------------------------------------------------------------
    // handshake outputs, straight from the state
    // ------------------------------------------------------------------------
    assign axil_rsp.awready = (state == IDLE) || (state == DATA_HELD);
    assign axil_rsp.wready  = (state == IDLE) || (state == ADDR_HELD);
    // a write offered in the same cycle wins over the read
    assign axil_rsp.arready = (state == IDLE) && !axil_req.awvalid && !axil_req.wvalid;
    assign axil_rsp.bvalid  = (state == WRITE_RESP);
    assign axil_rsp.bresp   = RESP_OKAY;
    assign axil_rsp.rvalid  = (state == READ_RESP);
    assign axil_rsp.rdata   = rdata_q;
    assign axil_rsp.rresp   = RESP_OKAY;

    assign aw_hs = axil_req.awvalid && axil_rsp.awready;
    assign w_hs  = axil_req.wvalid && axil_rsp.wready;
    assign ar_hs = axil_req.arvalid && axil_rsp.arready;

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state    <= IDLE;
            wr_pulse <= 1'b0;
        end else begin
            wr_pulse <= 1'b0;
            case (state)
                IDLE: begin
                    if (aw_hs && w_hs) begin
                        state    <= WRITE_RESP;
                        wr_pulse <= 1'b1;
                    end else if (aw_hs) begin
                        state <= ADDR_HELD;
                    end else if (w_hs) begin
                        state <= DATA_HELD;
                    end else if (ar_hs) begin
                        state <= READ_FETCH;
                    end
                end
                ADDR_HELD: begin
                    if (w_hs) begin
                        state    <= WRITE_RESP;
                        wr_pulse <= 1'b1;
                    end
                end
                DATA_HELD: begin
                    if (aw_hs) begin
                        state    <= WRITE_RESP;
                        wr_pulse <= 1'b1;
                    end
                end
                WRITE_RESP: begin
                    if (axil_req.bready) begin
                        state <= IDLE;
                    end
                end
                // register file answers in one cycle
                READ_FETCH: state <= READ_RESP;
                READ_RESP: begin
                    if (axil_req.rready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // latched address and data
    always_ff @(posedge AXIS_ACLK) begin
        if (aw_hs) begin
            wr_addr <= word_ofs(axil_req.awaddr);
        end
        if (w_hs) begin
            wr_data <= axil_req.wdata;
        end
        if (ar_hs) begin
            rd_addr <= word_ofs(axil_req.araddr);
        end
        if (state == READ_FETCH) begin
            rdata_q <= rd_data;
        end
    end

    assign reg_wr.valid = wr_pulse;
    assign reg_wr.ofs   = wr_addr;
    assign reg_wr.data  = wr_data;

    assign rd_ofs = rd_addr;

endmodule

`default_nettype wire

// File: verilog/ctrl_regs.sv
`default_nettype none
`timescale 1ns/1ns

module ctrl_regs (
    input  logic                            AXIS_ACLK,
    input  logic                            S_AXI_ARESETN,
    input  axil_pkg::reg_wr_t               reg_wr,
    input  logic [axil_pkg::ADDR_W-1:0]     rd_ofs,
    output logic [axil_pkg::DATA_W-1:0]     rd_data,
    input  logic                            gen_done,
    output logic                            gen,
    output logic [itemgen_pkg::ITEM_A_W-1:0] item_last
);
    import axil_pkg::*;
    import itemgen_pkg::*;

    logic ctrl_wr;
    logic last_wr;

    assign ctrl_wr = reg_wr.valid && (reg_wr.ofs == REG_CTRL_OFS);
    assign last_wr = reg_wr.valid && (reg_wr.ofs == REG_ITEM_LAST_OFS);

    // gen self-clears after the last item, a bus write wins
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            gen       <= 1'b0;
            item_last <= '0;
        end else begin
            if (ctrl_wr) begin
                gen <= reg_wr.data[0];
            end else if (gen_done) begin
                gen <= 1'b0;
            end
            if (last_wr) begin
                item_last <= reg_wr.data[ITEM_A_W-1:0];
            end
        end
    end

    // read mux, unmapped offsets return zero
    always_comb begin
        rd_data = '0;
        case (rd_ofs)
            REG_CTRL_OFS:      rd_data[0] = gen;
            REG_ITEM_LAST_OFS: rd_data[ITEM_A_W-1:0] = item_last;
            default:           rd_data = {DATA_W{1'b0}};
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/hv_generator.sv
`default_nettype none
`timescale 1ns/1ns

module hv_generator (
    input  logic                                AXIS_ACLK,
    input  logic                                gen,
    input  logic [itemgen_pkg::WORD_IDX_W-1:0]  word_idx,
    input  logic                                item_done,
    input  logic [itemgen_pkg::ITEM_A_W-1:0]    item_a,
    output itemgen_pkg::item_wr_t               item_wr
);
    import itemgen_pkg::*;

    logic [WORD_W-1:0]                xs_state;
    logic [WORD_W-1:0]                xs_next;
    logic [HV_WORDS-1:0][WORD_W-1:0]  hv_q;

    // one xorshift32 step
    function automatic logic [WORD_W-1:0] xs_step(input logic [WORD_W-1:0] x);
        logic [WORD_W-1:0] t;
        t = x ^ (x << XS_A);
        t = t ^ (t >> XS_B);
        t = t ^ (t << XS_C);
        return t;
    endfunction

    assign xs_next = xs_step(xs_state);

    // ------------------------------------------------------------------------
    // generator state, back to seed whenever gen drops
    // ------------------------------------------------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!gen) begin
            xs_state <= PRNG_SEED;
        end else begin
            xs_state <= xs_next;
        end
    end

    // ------------------------------------------------------------------------
    // hypervector assembly, one word per cycle
    // ------------------------------------------------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!gen) begin
            hv_q <= '0;
        end else begin
            hv_q[word_idx] <= xs_state;
        end
    end

    // the register still holds the whole vector during the done cycle,
    // word 0 of the next item lands at its end
    assign item_wr.valid  = item_done;
    assign item_wr.addr   = item_a;
    assign item_wr.vector = hv_q;

endmodule

`default_nettype wire

// File: verilog/item_counter.sv
`default_nettype none
`timescale 1ns/1ns

module item_counter (
    input  logic                                AXIS_ACLK,
    input  logic                                gen,
    input  logic [itemgen_pkg::ITEM_A_W-1:0]    item_last,
    output logic [itemgen_pkg::WORD_IDX_W-1:0]  word_idx,
    output logic                                item_done,
    output logic [itemgen_pkg::ITEM_A_W-1:0]    item_a,
    output logic                                gen_done
);
    import itemgen_pkg::*;

    logic last_word;

    assign last_word = (word_idx == WORD_IDX_W'(HV_WORDS - 1));

    // everything sits at zero while gen is low
    always_ff @(posedge AXIS_ACLK) begin
        if (!gen) begin
            word_idx  <= '0;
            item_done <= 1'b0;
            item_a    <= '0;
        end else begin
            if (last_word) begin
                word_idx <= '0;
            end else begin
                word_idx <= word_idx + 1'b1;
            end
            // vector is complete one cycle after its last word
            item_done <= last_word;
            if (item_done) begin
                item_a <= item_a + 1'b1;
            end
        end
    end

    // final item leaves this cycle
    assign gen_done = item_done && (item_a == item_last);

endmodule

`default_nettype wire

// File: verilog/item_memory_gen_top.sv
`default_nettype none
`timescale 1ns/1ns

module item_memory_gen_top (
    input  logic                    AXIS_ACLK,
    input  logic                    S_AXI_ARESETN,
    input  axil_pkg::axil_req_t     axil_req,
    output axil_pkg::axil_rsp_t     axil_rsp,
    output itemgen_pkg::item_wr_t   item_wr
);
    import axil_pkg::*;
    import itemgen_pkg::*;

    // bus side
    reg_wr_t             reg_wr;
    logic [ADDR_W-1:0]   rd_ofs;
    logic [DATA_W-1:0]   rd_data;

    // control
    logic                gen;
    logic                gen_done;
    logic [ITEM_A_W-1:0] item_last;

    // generation
    logic [WORD_IDX_W-1:0] word_idx;
    logic                  item_done;
    logic [ITEM_A_W-1:0]   item_a;

    axil_slave_fsm u_axil_slave_fsm (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .axil_req      (axil_req),
        .axil_rsp      (axil_rsp),
        .reg_wr        (reg_wr),
        .rd_ofs        (rd_ofs),
        .rd_data       (rd_data)
    );

    ctrl_regs u_ctrl_regs (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .reg_wr        (reg_wr),
        .rd_ofs        (rd_ofs),
        .rd_data       (rd_data),
        .gen_done      (gen_done),
        .gen           (gen),
        .item_last     (item_last)
    );

    item_counter u_item_counter (
        .AXIS_ACLK (AXIS_ACLK),
        .gen       (gen),
        .item_last (item_last),
        .word_idx  (word_idx),
        .item_done (item_done),
        .item_a    (item_a),
        .gen_done  (gen_done)
    );

    hv_generator u_hv_generator (
        .AXIS_ACLK (AXIS_ACLK),
        .gen       (gen),
        .word_idx  (word_idx),
        .item_done (item_done),
        .item_a    (item_a),
        .item_wr   (item_wr)
    );

endmodule

`default_nettype wire

// File: verilog/itemgen_pkg.sv
`default_nettype none

package itemgen_pkg;

    // hypervector geometry
    localparam int WORD_W     = 32;
    localparam int HV_WORDS   = 8;
    localparam int HV_W       = HV_WORDS * WORD_W;
    localparam int WORD_IDX_W = $clog2(HV_WORDS);

    // up to 1024 item memories
    localparam int ITEM_A_W = 10;

    // ------------------------------------------------------------------------
    // xorshift32 constants
    // ------------------------------------------------------------------------
    localparam logic [WORD_W-1:0] PRNG_SEED = 32'h92D68CA2;

    localparam int XS_A = 13;
    localparam int XS_B = 17;
    localparam int XS_C = 5;

    // finished hypervector toward the item memories
    // word k sits in bits [32k+31:32k]
    typedef struct packed {
        logic                valid;
        logic [ITEM_A_W-1:0] addr;
        logic [HV_W-1:0]     vector;
    } item_wr_t;

endpackage

`default_nettype wire
